// File: design/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP_INST 32'h0000_0013

`endif

// File: design/rv_pkg.sv
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // alu functions
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // ==========================================================================
  // stage registers
  // ==========================================================================

  typedef struct packed {
    logic                 valid;
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  inst;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic [`RV_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    logic                  alu_src_imm; // op2 from imm
    logic                  op1_pc;      // op1 from pc, auipc
    logic                  reg_write;
    logic                  illegal;
  } id_ex_t;

  // shared by ex/mem and mem/wb
  typedef struct packed {
    logic                  valid;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   result;
    logic                  reg_write;
    logic                  illegal;
  } result_t;

  // one record per instruction leaving write-back
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } retire_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module reg_file (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`RV_REG_AW-1:0] raddr1_i,
  input  logic [`RV_REG_AW-1:0] raddr2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  input  rv_pkg::result_t       wb_i
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs_q [1:(1 << `RV_REG_AW)-1];
  logic                wr_en;

  assign wr_en = wb_i.valid && wb_i.reg_write && (wb_i.rd != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < (1 << `RV_REG_AW); i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.rd] <= wb_i.result;
    end
  end

  // write-through, decode sees the value being written this cycle
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else if (wr_en && (wb_i.rd == raddr1_i)) begin
      rdata1_o = wb_i.result;
    end else begin
      rdata1_o = regs_q[raddr1_i];
    end

    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else if (wr_en && (wb_i.rd == raddr2_i)) begin
      rdata2_o = wb_i.result;
    end else begin
      rdata2_o = regs_q[raddr2_i];
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module fetch_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [`RV_XLEN-1:0] imem_data_i,
  output rv_pkg::if_id_t      if_id_o
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_plus_4;

  // no redirects, the pc only ever steps forward
  assign pc_plus_4   = pc_q + `RV_XLEN'd4;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= pc_plus_4;
    end
  end

  // ==========================================================================
  // IF/ID register
  // ==========================================================================

  // word comes back in the same cycle as the address
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o.valid <= 1'b0;
      if_id_o.pc    <= `RV_RESET_PC;
      if_id_o.inst  <= `RV_NOP_INST;
    end else begin
      if_id_o.valid <= 1'b1;
      if_id_o.pc    <= pc_q;
      if_id_o.inst  <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module decode_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  rv_pkg::if_id_t        if_id_i,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  output rv_pkg::id_ex_t        id_ex_o
);

  import rv_pkg::*;

  logic [`RV_XLEN-1:0]   inst;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_REG_AW-1:0] rd;
  logic                  f7_zero;
  logic                  f7_alt;
  logic [`RV_XLEN-1:0]   imm;
  alu_op_e               alu_op;
  logic                  alu_src_imm;
  logic                  op1_pc;
  logic                  reg_write;
  logic                  illegal;
  id_ex_t                id_ex_d;

  // field split
  assign inst    = if_id_i.inst;
  assign opcode  = opcode_e'(inst[6:0]);
  assign rd      = inst[11:7];
  assign funct3  = inst[14:12];
  assign rs1_o   = inst[19:15];
  assign rs2_o   = inst[24:20];
  assign funct7  = inst[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // ==========================================================================
  // main decoder and immediate
  // ==========================================================================

  always_comb begin
    alu_op      = ADD;
    alu_src_imm = 1'b0;
    op1_pc      = 1'b0;
    reg_write   = 1'b0;
    illegal     = 1'b0;
    imm         = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};

    case (opcode)
      OP, OP_IMM: begin
        reg_write   = 1'b1;
        alu_src_imm = (opcode == OP_IMM);
        case (funct3)
          3'b000:  alu_op = (opcode == OP && f7_alt) ? SUB : ADD;
          3'b001:  alu_op = SLL;
          3'b010:  alu_op = SLT;
          3'b011:  alu_op = SLTU;
          3'b100:  alu_op = XOR;
          3'b101:  alu_op = f7_alt ? SRA : SRL;
          3'b110:  alu_op = OR;
          default: alu_op = AND;
        endcase
        // funct7 only matters for register ops and immediate shifts
        if (opcode == OP) begin
          illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end else if (funct3 == 3'b001) begin
          illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(f7_zero || f7_alt);
        end
      end
      LUI, AUIPC: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        op1_pc      = (opcode == AUIPC);
        alu_op      = (opcode == LUI) ? PASS_B : ADD;
        imm         = {inst[31:12], 12'b0};
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      reg_write = 1'b0;
    end
  end

  assign id_ex_d = '{
    valid:       if_id_i.valid,
    pc:          if_id_i.pc,
    rs1:         rs1_o,
    rs2:         rs2_o,
    rd:          rd,
    rdata1:      rdata1_i,
    rdata2:      rdata2_i,
    imm:         imm,
    alu_op:      alu_op,
    alu_src_imm: alu_src_imm,
    op1_pc:      op1_pc,
    reg_write:   reg_write,
    illegal:     illegal
  };

  // ID/EX register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module alu (
  input  rv_pkg::alu_op_e     alu_op_i,
  input  logic [`RV_XLEN-1:0] a_i,
  input  logic [`RV_XLEN-1:0] b_i,
  output logic [`RV_XLEN-1:0] result_o
);

  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount from the low five bits only
  assign shamt       = b_i[4:0];
  assign lt_signed   = ($signed(a_i) < $signed(b_i));
  assign lt_unsigned = (a_i < b_i);

  always_comb begin
    case (alu_op_i)
      ADD:     result_o = a_i + b_i;
      SUB:     result_o = a_i - b_i;
      SLL:     result_o = a_i << shamt;
      SLT:     result_o = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      SLTU:    result_o = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      XOR:     result_o = a_i ^ b_i;
      SRL:     result_o = a_i >> shamt;
      SRA:     result_o = $unsigned($signed(a_i) >>> shamt);
      OR:      result_o = a_i | b_i;
      AND:     result_o = a_i & b_i;
      // lui, the immediate goes straight through
      PASS_B:  result_o = b_i;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module execute_stage (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  rv_pkg::id_ex_t  id_ex_i,
  output rv_pkg::result_t wb_o
);

  import rv_pkg::*;

  result_t             ex_mem_q;
  result_t             ex_mem_d;
  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] alu_result;

  // a later stage holds a pending write to this source
  function automatic logic fwd_hit(input result_t stage, input logic [`RV_REG_AW-1:0] rs);
    return stage.valid && stage.reg_write && (stage.rd != '0) && (stage.rd == rs);
  endfunction

  // ==========================================================================
  // operand forwarding
  // ==========================================================================

  // youngest producer wins, ex/mem before mem/wb
  always_comb begin
    if (fwd_hit(ex_mem_q, id_ex_i.rs1)) begin
      rs1_fwd = ex_mem_q.result;
    end else if (fwd_hit(wb_o, id_ex_i.rs1)) begin
      rs1_fwd = wb_o.result;
    end else begin
      rs1_fwd = id_ex_i.rdata1;
    end

    if (fwd_hit(ex_mem_q, id_ex_i.rs2)) begin
      rs2_fwd = ex_mem_q.result;
    end else if (fwd_hit(wb_o, id_ex_i.rs2)) begin
      rs2_fwd = wb_o.result;
    end else begin
      rs2_fwd = id_ex_i.rdata2;
    end
  end

  assign op1 = id_ex_i.op1_pc ? id_ex_i.pc : rs1_fwd;
  assign op2 = id_ex_i.alu_src_imm ? id_ex_i.imm : rs2_fwd;

  alu alu_inst (
    .alu_op_i (id_ex_i.alu_op),
    .a_i      (op1),
    .b_i      (op2),
    .result_o (alu_result)
  );

  assign ex_mem_d = '{
    valid:     id_ex_i.valid,
    rd:        id_ex_i.rd,
    result:    alu_result,
    reg_write: id_ex_i.reg_write,
    illegal:   id_ex_i.illegal
  };

  // ==========================================================================
  // EX/MEM and MEM/WB registers
  // ==========================================================================

  // no memory access, mem only delays the result by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_mem_q <= '0;
      wb_o     <= '0;
    end else begin
      ex_mem_q <= ex_mem_d;
      wb_o     <= ex_mem_q;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [`RV_XLEN-1:0] imem_data_i,
  output rv_pkg::retire_t     retire_o
);

  import rv_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  result_t               wb;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;

  fetch_stage fetch_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .if_id_o     (if_id)
  );

  decode_stage decode_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .if_id_i  (if_id),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .id_ex_o  (id_ex)
  );

  reg_file reg_file_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb)
  );

  execute_stage execute_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .id_ex_i (id_ex),
    .wb_o    (wb)
  );

  // retire record straight from mem/wb, x0 writes are not reported as writes
  assign retire_o = '{
    valid:   wb.valid,
    illegal: wb.illegal,
    we:      wb.reg_write && (wb.rd != '0),
    rd:      wb.rd,
    data:    wb.result
  };

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

  import rv_pkg::*;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 16;
  localparam int          RAND_COUNT   = 200;
  localparam int          MARGIN       = 20;
  localparam int          STIM_DEPTH   = 256;
  localparam int          IMEM_DEPTH   = 1024;
  localparam logic [31:0] MARKER       = 32'hffff_ffff;

  logic                clk;
  logic                rst_n;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_data;
  retire_t             retire;

  logic [31:0] stim_mem [0:STIM_DEPTH-1];
  logic [31:0] imem [0:IMEM_DEPTH-1];
  logic [31:0] ref_regs [0:31];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] fetch_addr_q [$];
  int          fetch_cycle_q [$];

  logic [31:0] lfsr_q;
  logic [31:0] exp_addr;
  logic        stim_ok;
  logic        stim_loaded;
  logic        directed_done;
  logic        random_done;
  int          prog_len;
  int          cycle;
  int          errors;
  int          errs_mark;
  int          tests_run;
  int          tests_passed;

  rv_core_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .retire_o    (retire)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // instruction memory answers in the same cycle
  assign imem_data = (imem_addr < 32'(IMEM_DEPTH * 4)) ? imem[imem_addr[11:2]] : `RV_NOP_INST;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - errs_mark;
    tests_run++;
    if (n == 0) begin
      tests_passed++;
    end
    $display("test %-22s %0d errors", name, n);
    errs_mark = errors;
  endtask

  // ==========================================================================
  // random instructions
  // ==========================================================================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // registers x0 to x15 only so dependencies are frequent
  task automatic make_random_inst(output logic [31:0] inst);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic        use_imm;
    logic        alt;
    take_bits(1, r);
    use_imm = r[0];
    take_bits(3, r);
    f3 = r[2:0];
    take_bits(4, r);
    rd = {1'b0, r[3:0]};
    take_bits(4, r);
    rs1 = {1'b0, r[3:0]};
    take_bits(1, r);
    alt = r[0];
    if (use_imm) begin
      take_bits(12, r);
      imm = r[11:0];
      if (f3 == 3'd1) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'd5) begin
        imm[11:5] = alt ? 7'h20 : 7'h00;
      end
      inst = {imm, rs1, f3, rd, 7'h13};
    end else begin
      take_bits(4, r);
      rs2 = {1'b0, r[3:0]};
      inst = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
    end
  endtask

  // ==========================================================================
  // ISA model
  // ==========================================================================

  task automatic model_step(input logic [31:0] inst, input logic [31:0] pc,
                            output logic ill, output logic we,
                            output logic [4:0] rd, output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        is_imm;
    a      = ref_regs[inst[19:15]];
    b      = ref_regs[inst[24:20]];
    f7     = inst[31:25];
    f3     = inst[14:12];
    rd     = inst[11:7];
    is_imm = (inst[6:0] == 7'h13);
    ill    = 1'b0;
    data   = '0;
    case (inst[6:0])
      7'h37: data = {inst[31:12], 12'h000};
      7'h17: data = pc + {inst[31:12], 12'h000};
      7'h33, 7'h13: begin
        if (is_imm) begin
          b = {{20{inst[31]}}, inst[31:20]};
        end
        case (f3)
          3'd0:    data = (!is_imm && f7 == 7'h20) ? a - b : a + b;
          3'd1:    data = a << b[4:0];
          3'd2:    data = {31'd0, ($signed(a) < $signed(b))};
          3'd3:    data = {31'd0, (a < b)};
          3'd4:    data = a ^ b;
          3'd5:    data = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6:    data = a | b;
          default: data = a & b;
        endcase
        if (!is_imm) begin
          ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        end else if (f3 == 3'd1) begin
          ill = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          ill = !(f7 == 7'h00 || f7 == 7'h20);
        end
      end
      default: ill = 1'b1;
    endcase
    we = !ill && (rd != 5'd0);
    if (we) begin
      ref_regs[rd] = data;
    end
  endtask

  // program words up to a marker then rd and data pairs up to a marker
  task automatic load_stimulus();
    int idx;
    stim_ok = 1'b0;
    $readmemh("testbench/rv_stimulus.mem", stim_mem);
    idx = 0;
    while (idx < STIM_DEPTH && stim_mem[idx] !== MARKER && !$isunknown(stim_mem[idx])) begin
      idx++;
    end
    if (idx >= STIM_DEPTH || stim_mem[idx] !== MARKER) begin
      return;
    end
    prog_len = idx;
    idx++;
    while (idx + 1 < STIM_DEPTH && stim_mem[idx] !== MARKER && !$isunknown(stim_mem[idx])) begin
      exp_rd_q.push_back(stim_mem[idx][4:0]);
      exp_data_q.push_back(stim_mem[idx + 1]);
      idx += 2;
    end
    stim_ok = (idx < STIM_DEPTH) && (stim_mem[idx] === MARKER);
  endtask

  task automatic check_retire();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic [4:0]  rd;
    logic [4:0]  exp_rd;
    logic        ill;
    logic        we;
    int          fcycle;
    if (fetch_addr_q.size() == 0) begin
      $display("retire record in cycle %0d has no matching fetch", cycle);
      errors++;
      return;
    end
    addr   = fetch_addr_q.pop_front();
    fcycle = fetch_cycle_q.pop_front();
    check_val("retire latency", 32'(cycle - fcycle), 32'd4);
    model_step(imem[addr[11:2]], addr, ill, we, rd, data);
    check_val("retire_o.illegal", {31'd0, retire.illegal}, {31'd0, ill});
    check_val("retire_o.we", {31'd0, retire.we}, {31'd0, we});
    check_val("retire_o.rd", {27'd0, retire.rd}, {27'd0, rd});
    if (we) begin
      check_val("retire_o.data", retire.data, data);
    end
    if (addr < 32'(prog_len * 4)) begin
      if (retire.we && exp_rd_q.size() == 0) begin
        $display("directed program wrote more registers than the stimulus file lists");
        errors++;
      end else if (retire.we) begin
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        check_val("retire_o.rd", {27'd0, retire.rd}, {27'd0, exp_rd});
        check_val("retire_o.data", retire.data, exp_data);
      end
      if (addr == 32'((prog_len - 1) * 4)) begin
        directed_done = 1'b1;
      end
    end else if (addr == 32'((prog_len + RAND_COUNT - 1) * 4)) begin
      random_done = 1'b1;
    end
  endtask

  // ==========================================================================
  // monitor sampled on the falling edge
  // ==========================================================================

  always @(negedge clk) begin
    if (!rst_n) begin
      check_val("retire_o.valid", {31'd0, retire.valid}, 32'd0);
      check_val("imem_addr_o", imem_addr, `RV_RESET_PC);
    end else begin
      cycle++;
      exp_addr = `RV_RESET_PC + 32'((cycle - 1) * 4);
      check_val("imem_addr_o", imem_addr, exp_addr);
      fetch_addr_q.push_back(exp_addr);
      fetch_cycle_q.push_back(cycle);
      if (retire.valid) begin
        check_retire();
      end
    end
  end

  initial begin
    int          i;
    logic [31:0] word;
    clk           = 1'b0;
    rst_n         = 1'b0;
    lfsr_q        = 32'hf9bd;
    stim_loaded   = 1'b0;
    directed_done = 1'b0;
    random_done   = 1'b0;
    prog_len      = 0;
    cycle         = 0;
    errors        = 0;
    errs_mark     = 0;
    tests_run     = 0;
    tests_passed  = 0;
    exp_addr      = `RV_RESET_PC;
    for (i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    load_stimulus();
    stim_loaded = 1'b1;
    if (!stim_ok) begin
      $display("stimulus file is missing an end marker");
      errors++;
    end else begin
      for (i = 0; i < IMEM_DEPTH; i++) begin
        imem[i] = `RV_NOP_INST;
      end
      for (i = 0; i < prog_len; i++) begin
        imem[i] = stim_mem[i];
      end
      // random program follows the directed one
      for (i = 0; i < RAND_COUNT; i++) begin
        make_random_inst(word);
        imem[prog_len + i] = word;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      end_test("reset");
      wait (directed_done);
      check_val("unused expected records", 32'(exp_rd_q.size()), 32'd0);
      end_test("directed alu program");
      wait (random_done);
      end_test("random program");
    end
    $display("%0d tests, %0d passed, %0d errors", tests_run, tests_passed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (stim_loaded);
    #((prog_len + RAND_COUNT + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout, the program did not finish retiring in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/rv_stimulus.mem
// program words, four per line, ended by the ffffffff marker
// then expected retire records with we set, as rd data pairs, ended by ffffffff
12300093 fff08113 002081b3 40118233  // 0x00 addi, addi and add and sub chains
800002b7 00001317 0012a3b3 0012b433  // 0x10 lui, auipc, slt, sltu
fff2a493 fff0b513 0062c5b3 0ff5c613  // 0x20 slti, sltiu, xor, xori
0060e6b3 70066713 00b777b3 0f077813  // 0x30 or, ori, and, andi
003098b3 00489913 0022d9b3 4022da33  // 0x40 sll, slli, srl, sra
008a5a93 408a5b13 00508013 00100bb3  // 0x50 srli, srai, addi to x0, add from x0
00108b8b 001b8c13 417c0cb3           // 0x60 bad opcode aimed at x23, reads of x23
ffffffff
01 00000123  02 00000122
03 00000245  04 00000122
05 80000000  06 00001014
07 00000001  08 00000000
09 00000001  0a 00000001
0b 80001014  0c 800010eb
0d 00001137  0e 800017eb
0f 80001000  10 000000e0
11 00002460  12 00024600
13 20000000  14 e0000000
15 00e00000  16 ffe00000
17 00000123  18 00000124
19 00000001
ffffffff

// File: tb.f
+incdir+design
design/rv_pkg.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Makefile
SIM  := obj_dir/Vtb_rv_core
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) tb.f
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_rv_core

run: $(SIM) testbench/rv_stimulus.mem
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
